// ==== common/usb_macros.svh ====
// USB transmit constants
`ifndef USB_MACROS_SVH
`define USB_MACROS_SVH

// field lengths in bits
`define USB_SYNC_BITS 8
`define USB_PID_BITS 8
`define USB_ADDR_BITS 7
`define USB_ENDP_BITS 4
`define USB_DATA_BITS 64
`define USB_CRC5_BITS 5
`define USB_CRC16_BITS 16

// ones allowed in a row before a zero is stuffed
`define USB_STUFF_RUN 6
`define USB_EOP_SE0_CYCLES 2

// crc generators and seeds
`define USB_CRC5_INIT 5'h1f
`define USB_CRC16_INIT 16'hffff
`define USB_CRC5_POLY 5'h05
`define USB_CRC16_POLY 16'h8005

`endif

// ==== common/usb_pkt_pkg.sv ====
// USB packet types
`include "usb_macros.svh"

package usb_pkt_pkg;

  // pid byte as it goes on the wire, check nibble included
  typedef enum logic [`USB_PID_BITS-1:0] {
    PID_OUT   = 8'hE1,
    PID_IN    = 8'h69,
    PID_DATA0 = 8'hC3,
    PID_ACK   = 8'hD2,
    PID_NAK   = 8'h5A
  } pid_t;

  typedef logic [`USB_ADDR_BITS-1:0] addr_t;
  typedef logic [`USB_ENDP_BITS-1:0] endp_t;
  typedef logic [`USB_DATA_BITS-1:0] payload_t;

  // fields that a packet type does not carry are don't care
  typedef struct packed {
    pid_t     pid;
    addr_t    addr;
    endp_t    endp;
    payload_t payload;
  } usb_pkt_t;

  // one serial bit between encoder, stuffer and line driver
  typedef struct packed {
    logic valid;
    logic value;
    logic stuffable;
    logic last;
  } tx_bit_t;

endpackage

// ==== common/usb_line_pkg.sv ====
// USB line level types

package usb_line_pkg;

  // symbol encoded as {dp, dm}
  typedef enum logic [1:0] {
    LINE_SE0 = 2'b00,
    LINE_K   = 2'b01,
    LINE_J   = 2'b10
  } line_sym_t;

  // oe low means the port is not driving
  typedef struct packed {
    logic oe;
    logic dp;
    logic dm;
  } usb_line_t;

endpackage

// ==== hw/tx/usb_crc_serial.sv ====
// Serial CRC generator
`timescale 1ns/1ns

module usb_crc_serial #(
  parameter int               CRC_W    = 5,
  parameter logic [CRC_W-1:0] CRC_POLY = '0,
  parameter logic [CRC_W-1:0] CRC_INIT = '1
) (
  input  logic clk,
  input  logic rst_L,
  input  logic start,
  input  logic shift_in,
  input  logic bit_in,
  input  logic shift_out,
  output logic crc_bit
);

  logic [CRC_W-1:0] crc;
  logic             feedback;

  assign feedback = crc[CRC_W-1] ^ bit_in;

  // remainder goes out inverted, msb first
  assign crc_bit = ~crc[CRC_W-1];

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      crc <= CRC_INIT;
    end else if (start) begin
      crc <= CRC_INIT;
    end else if (shift_in) begin
      // galois form, one message bit per cycle
      crc <= {crc[CRC_W-2:0], 1'b0} ^ (feedback ? CRC_POLY : '0);
    end else if (shift_out) begin
      crc <= {crc[CRC_W-2:0], 1'b0};
    end
  end

endmodule

// ==== hw/tx/usb_pkt_encoder.sv ====
// Packet field sequencer
`timescale 1ns/1ns
`include "usb_macros.svh"

module usb_pkt_encoder
  import usb_pkt_pkg::*;
(
  input  logic     clk,
  input  logic     rst_L,
  input  usb_pkt_t pkt,
  input  logic     pkt_valid,
  input  logic     stall,
  input  logic     pkt_sent,
  output tx_bit_t  enc_bit,
  output logic     busy
);

  typedef enum logic [2:0] {
    IDLE, SYNC, PID, ADDR, ENDP, DATA, CRC, EOP_WAIT
  } enc_state_t;

  enc_state_t state;
  usb_pkt_t   pkt_q;
  logic [5:0] bit_cnt;
  logic [5:0] field_max;
  logic       accept;
  logic       field_end;
  logic       is_token;
  logic       is_data;
  logic       body_bit;
  logic       crc5_bit;
  logic       crc16_bit;
  logic       crc5_shift_in;
  logic       crc5_shift_out;
  logic       crc16_shift_in;
  logic       crc16_shift_out;

  assign accept   = pkt_valid && (state == IDLE);
  assign busy     = (state != IDLE);
  assign is_token = (pkt_q.pid == PID_OUT) || (pkt_q.pid == PID_IN);
  assign is_data  = (pkt_q.pid == PID_DATA0);

  // index of the final bit in the current field
  always_comb begin
    case (state)
      SYNC:    field_max = 6'(`USB_SYNC_BITS - 1);
      PID:     field_max = 6'(`USB_PID_BITS - 1);
      ADDR:    field_max = 6'(`USB_ADDR_BITS - 1);
      ENDP:    field_max = 6'(`USB_ENDP_BITS - 1);
      DATA:    field_max = 6'(`USB_DATA_BITS - 1);
      CRC:     field_max = is_token ? 6'(`USB_CRC5_BITS - 1) : 6'(`USB_CRC16_BITS - 1);
      default: field_max = '0;
    endcase
  end

  assign field_end = (bit_cnt == field_max);

  // crc covered bits, lsb first
  always_comb begin
    case (state)
      ADDR:    body_bit = pkt_q.addr[bit_cnt[2:0]];
      ENDP:    body_bit = pkt_q.endp[bit_cnt[1:0]];
      DATA:    body_bit = pkt_q.payload[bit_cnt];
      default: body_bit = 1'b0;
    endcase
  end

  always_comb begin
    enc_bit = '0;
    case (state)
      SYNC: begin
        // seven zeros then a one
        enc_bit.valid = 1'b1;
        enc_bit.value = field_end;
      end
      PID: begin
        enc_bit.valid     = 1'b1;
        enc_bit.value     = pkt_q.pid[bit_cnt[2:0]];
        enc_bit.stuffable = 1'b1;
        // handshakes end right after the pid
        enc_bit.last      = field_end && !is_token && !is_data;
      end
      ADDR, ENDP, DATA: begin
        enc_bit.valid     = 1'b1;
        enc_bit.value     = body_bit;
        enc_bit.stuffable = 1'b1;
      end
      CRC: begin
        enc_bit.valid     = 1'b1;
        enc_bit.value     = is_token ? crc5_bit : crc16_bit;
        enc_bit.stuffable = 1'b1;
        enc_bit.last      = field_end;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pkt_q <= pkt;
    end
  end

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else if (accept) begin
      state   <= SYNC;
      bit_cnt <= '0;
    end else if (!stall) begin
      bit_cnt <= field_end ? '0 : bit_cnt + 6'd1;
      case (state)
        SYNC: if (field_end) state <= PID;
        PID: begin
          if (field_end) begin
            if (is_token)
              state <= ADDR;
            else if (is_data)
              state <= DATA;
            else
              state <= EOP_WAIT;
          end
        end
        ADDR: if (field_end) state <= ENDP;
        ENDP: if (field_end) state <= CRC;
        DATA: if (field_end) state <= CRC;
        CRC:  if (field_end) state <= EOP_WAIT;
        // hold busy until the line driver finishes the eop
        EOP_WAIT: if (pkt_sent) state <= IDLE;
        default: ;
      endcase
    end
  end

  assign crc5_shift_in   = !stall && ((state == ADDR) || (state == ENDP));
  assign crc5_shift_out  = !stall && (state == CRC) && is_token;
  assign crc16_shift_in  = !stall && (state == DATA);
  assign crc16_shift_out = !stall && (state == CRC) && !is_token;

  usb_crc_serial #(
    .CRC_W    (`USB_CRC5_BITS),
    .CRC_POLY (`USB_CRC5_POLY),
    .CRC_INIT (`USB_CRC5_INIT)
  ) u_crc5 (
    .clk       (clk),
    .rst_L     (rst_L),
    .start     (accept),
    .shift_in  (crc5_shift_in),
    .bit_in    (body_bit),
    .shift_out (crc5_shift_out),
    .crc_bit   (crc5_bit)
  );

  usb_crc_serial #(
    .CRC_W    (`USB_CRC16_BITS),
    .CRC_POLY (`USB_CRC16_POLY),
    .CRC_INIT (`USB_CRC16_INIT)
  ) u_crc16 (
    .clk       (clk),
    .rst_L     (rst_L),
    .start     (accept),
    .shift_in  (crc16_shift_in),
    .bit_in    (body_bit),
    .shift_out (crc16_shift_out),
    .crc_bit   (crc16_bit)
  );

  // a new packet only arrives once the previous one has left the line
  assert property (@(posedge clk) disable iff (!rst_L) busy |-> !pkt_valid)
    else $error("pkt_valid raised while busy");

endmodule

// ==== hw/tx/usb_bit_stuffer.sv ====
// Zero bit stuffer
`timescale 1ns/1ns
`include "usb_macros.svh"

module usb_bit_stuffer
  import usb_pkt_pkg::*;
(
  input  logic    clk,
  input  logic    rst_L,
  input  tx_bit_t enc_bit,
  output tx_bit_t line_bit,
  output logic    stall
);

  logic [2:0] ones_run;
  logic       stuff_last;
  logic       one_in;
  logic       run_full;
  logic       line_one;

  assign one_in   = enc_bit.valid && enc_bit.stuffable && enc_bit.value;
  // this bit completes a run, so a zero goes out next cycle
  assign run_full = one_in && (ones_run == 3'(`USB_STUFF_RUN - 1));
  assign stall    = (ones_run == 3'(`USB_STUFF_RUN));

  always_comb begin
    if (stall) begin
      line_bit.valid     = 1'b1;
      line_bit.value     = 1'b0;
      line_bit.stuffable = 1'b1;
      line_bit.last      = stuff_last;
    end else begin
      line_bit      = enc_bit;
      // last moves to the stuffed zero when it closes a run
      line_bit.last = enc_bit.last && !run_full;
    end
  end

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      ones_run   <= '0;
      stuff_last <= 1'b0;
    end else if (stall) begin
      ones_run   <= '0;
      stuff_last <= 1'b0;
    end else begin
      ones_run   <= one_in ? ones_run + 3'd1 : '0;
      stuff_last <= enc_bit.last && run_full;
    end
  end

  assign line_one = line_bit.valid && line_bit.stuffable && line_bit.value;

  // never seven ones in a row after sync
  assert property (@(posedge clk) disable iff (!rst_L)
    !(line_one && $past(line_one, 1) && $past(line_one, 2) &&
      $past(line_one, 3) && $past(line_one, 4) && $past(line_one, 5) &&
      $past(line_one, 6)))
    else $error("seven consecutive ones left the stuffer");

endmodule

// ==== hw/usb_line_driver.sv ====
// NRZI line driver with EOP
`timescale 1ns/1ns
`include "usb_macros.svh"

module usb_line_driver
  import usb_pkt_pkg::*;
  import usb_line_pkg::*;
(
  input  logic      clk,
  input  logic      rst_L,
  input  tx_bit_t   line_bit,
  output usb_line_t line,
  output logic      pkt_sent
);

  typedef enum logic [2:0] {
    IDLE, PACKET, SE0_1, SE0_2, EOP_J
  } drv_state_t;

  drv_state_t state;
  line_sym_t  sym;
  logic       last_q;
  line_sym_t  sym_toggled;

  assign sym_toggled = (sym == LINE_J) ? LINE_K : LINE_J;

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      state  <= IDLE;
      sym    <= LINE_J;
      last_q <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (line_bit.valid) begin
            state  <= PACKET;
            // every packet starts from J
            sym    <= line_bit.value ? LINE_J : LINE_K;
            last_q <= line_bit.last;
          end
        end
        PACKET: begin
          if (last_q) begin
            state  <= SE0_1;
            last_q <= 1'b0;
          end else if (line_bit.valid) begin
            // a zero flips the level, a one holds it
            sym    <= line_bit.value ? sym : sym_toggled;
            last_q <= line_bit.last;
          end
        end
        SE0_1: state <= SE0_2;
        SE0_2: state <= EOP_J;
        EOP_J: begin
          state <= IDLE;
          sym   <= LINE_J;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    line.oe = (state != IDLE);
    case (state)
      PACKET:       {line.dp, line.dm} = sym;
      SE0_1, SE0_2: {line.dp, line.dm} = LINE_SE0;
      default:      {line.dp, line.dm} = LINE_J;
    endcase
  end

  assign pkt_sent = (state == EOP_J);

  assert property (@(posedge clk) disable iff (!rst_L) line.oe |-> !(line.dp && line.dm))
    else $error("dp and dm both driven high");

  // last bit, its symbol, the SE0 cycles, then J with pkt_sent
  assert property (@(posedge clk) disable iff (!rst_L)
    line_bit.valid && line_bit.last |-> ##(`USB_EOP_SE0_CYCLES + 2) pkt_sent)
    else $error("pkt_sent not at the end of eop");

endmodule

// ==== hw/usb_tx.sv ====
// USB transmit top
`timescale 1ns/1ns

module usb_tx
  import usb_pkt_pkg::*;
  import usb_line_pkg::*;
(
  input  logic      clk,
  input  logic      rst_L,
  input  usb_pkt_t  pkt,
  input  logic      pkt_valid,
  output usb_line_t line,
  output logic      busy,
  output logic      pkt_sent
);

  tx_bit_t enc_bit;
  tx_bit_t line_bit;
  logic    stall;

  usb_pkt_encoder u_encoder (
    .clk       (clk),
    .rst_L     (rst_L),
    .pkt       (pkt),
    .pkt_valid (pkt_valid),
    .stall     (stall),
    .pkt_sent  (pkt_sent),
    .enc_bit   (enc_bit),
    .busy      (busy)
  );

  usb_bit_stuffer u_stuffer (
    .clk      (clk),
    .rst_L    (rst_L),
    .enc_bit  (enc_bit),
    .line_bit (line_bit),
    .stall    (stall)
  );

  // pkt_sent also releases the encoder
  usb_line_driver u_driver (
    .clk      (clk),
    .rst_L    (rst_L),
    .line_bit (line_bit),
    .line     (line),
    .pkt_sent (pkt_sent)
  );

endmodule

// ==== tests/usb_tx_model.svh ====
// USB transmit reference model
`ifndef USB_TX_MODEL_SVH
`define USB_TX_MODEL_SVH

// complemented remainder over the first nbits of body, body fed lsb first
function automatic logic [15:0] ref_crc(input logic [63:0] body, input int nbits,
                                        input int width);
  logic [15:0] poly;
  logic [15:0] crc;
  logic        feedback;
  poly = (width == `USB_CRC5_BITS) ? 16'(`USB_CRC5_POLY) : `USB_CRC16_POLY;
  crc  = (width == `USB_CRC5_BITS) ? 16'(`USB_CRC5_INIT) : `USB_CRC16_INIT;
  for (int i = 0; i < nbits; i++) begin
    feedback = crc[width-1] ^ body[i];
    crc      = {crc[14:0], 1'b0} ^ (feedback ? poly : 16'h0);
  end
  return ~crc & ((16'h1 << width) - 16'h1);
endfunction

// unstuffed bit sequence of a packet, seq[0] goes out first
function automatic int ref_bits(input usb_pkt_t p, output logic [127:0] seq);
  int          n;
  logic [15:0] crc;
  seq = '0;
  n   = 0;
  // sync is seven zeros then a one
  for (int i = 0; i < `USB_SYNC_BITS; i++) begin
    seq[n] = (i == `USB_SYNC_BITS - 1);
    n++;
  end
  for (int i = 0; i < `USB_PID_BITS; i++) begin
    seq[n] = p.pid[i];
    n++;
  end
  if (p.pid == PID_OUT || p.pid == PID_IN) begin
    for (int i = 0; i < `USB_ADDR_BITS; i++) begin
      seq[n] = p.addr[i];
      n++;
    end
    for (int i = 0; i < `USB_ENDP_BITS; i++) begin
      seq[n] = p.endp[i];
      n++;
    end
    crc = ref_crc({53'h0, p.endp, p.addr}, `USB_ADDR_BITS + `USB_ENDP_BITS, `USB_CRC5_BITS);
    // crc goes msb first
    for (int i = `USB_CRC5_BITS - 1; i >= 0; i--) begin
      seq[n] = crc[i];
      n++;
    end
  end else if (p.pid == PID_DATA0) begin
    for (int i = 0; i < `USB_DATA_BITS; i++) begin
      seq[n] = p.payload[i];
      n++;
    end
    crc = ref_crc(p.payload, `USB_DATA_BITS, `USB_CRC16_BITS);
    for (int i = `USB_CRC16_BITS - 1; i >= 0; i--) begin
      seq[n] = crc[i];
      n++;
    end
  end
  return n;
endfunction

`endif

// ==== tests/tb_usb_tx.sv ====
// USB transmit testbench
`timescale 1ns/1ns
`include "usb_macros.svh"

module tb_usb_tx
  import usb_pkt_pkg::*;
  import usb_line_pkg::*;
();

  `include "usb_tx_model.svh"

  typedef enum logic [1:0] {
    TAG_HANDSHAKE, TAG_TOKEN, TAG_DATA, TAG_DATA_ONES
  } pkt_tag_t;

  typedef struct packed {
    pkt_tag_t tag;
    usb_pkt_t pkt;
  } stim_t;

  localparam int NUM_ENTRIES = 8;
  // worst case per packet: sync, pid, body and crc, stuffing, eop, strobe gap
  localparam int CYCLE_LIMIT = NUM_ENTRIES * (`USB_SYNC_BITS + `USB_PID_BITS +
                               `USB_DATA_BITS + `USB_CRC16_BITS + 16 + 3 + 4) + 2;

  logic      clk;
  logic      rst_L;
  usb_pkt_t  pkt;
  logic      pkt_valid;
  usb_line_t line;
  logic      busy;
  logic      pkt_sent;
  stim_t     stim [NUM_ENTRIES];
  int        cycles;

  usb_tx DUT (
    .clk       (clk),
    .rst_L     (rst_L),
    .pkt       (pkt),
    .pkt_valid (pkt_valid),
    .line      (line),
    .busy      (busy),
    .pkt_sent  (pkt_sent)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task fail_run();
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  task check_eq(input string name, input logic [127:0] exp, input logic [127:0] got);
    assert (exp === got) else begin
      $display("ERROR %s expected %0h got %0h", name, exp, got);
      fail_run();
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      fail_run();
    end
  end

  function automatic stim_t make_entry(input pkt_tag_t tag, input pid_t pid,
                                       input addr_t addr, input endp_t endp,
                                       input payload_t data);
    stim_t s;
    s.tag         = tag;
    s.pkt.pid     = pid;
    s.pkt.addr    = addr;
    s.pkt.endp    = endp;
    s.pkt.payload = data;
    return s;
  endfunction

  // strobe one packet, then decode the line until the end of EOP
  task automatic send_and_decode(input stim_t s);
    logic [127:0] exp_seq;
    logic [127:0] got_seq;
    int           exp_len;
    int           got_len;
    int           raw_cnt;
    int           ones;
    int           stuffed;
    logic [1:0]   prev_sym;
    logic [1:0]   cur_sym;
    logic         nrzi_bit;
    exp_len  = ref_bits(s.pkt, exp_seq);
    got_seq  = '0;
    got_len  = 0;
    raw_cnt  = 0;
    ones     = 0;
    stuffed  = 0;
    prev_sym = LINE_J;
    while (busy) @(negedge clk);
    @(posedge clk);
    #2;
    pkt       = s.pkt;
    pkt_valid = 1'b1;
    @(posedge clk);
    #2;
    pkt_valid = 1'b0;
    @(negedge clk);
    check_eq("busy", 1, busy);
    check_eq("line oe", 0, line.oe);
    @(negedge clk);
    cur_sym = {line.dp, line.dm};
    while (cur_sym != LINE_SE0) begin
      check_eq("line oe", 1, line.oe);
      check_eq("pkt_sent", 0, pkt_sent);
      nrzi_bit = (cur_sym == prev_sym);
      prev_sym = cur_sym;
      if (raw_cnt >= `USB_SYNC_BITS && ones == `USB_STUFF_RUN) begin
        // six ones must be followed by a level change
        check_eq("stuffed bit", 0, nrzi_bit);
        ones = 0;
        stuffed++;
      end else begin
        if (raw_cnt >= `USB_SYNC_BITS)
          ones = nrzi_bit ? ones + 1 : 0;
        got_seq[got_len] = nrzi_bit;
        got_len++;
      end
      raw_cnt++;
      @(negedge clk);
      cur_sym = {line.dp, line.dm};
    end
    check_eq("line oe", 1, line.oe);
    check_eq("pkt_sent", 0, pkt_sent);
    @(negedge clk);
    check_eq("line oe", 1, line.oe);
    check_eq("line dp dm", LINE_SE0, {line.dp, line.dm});
    check_eq("pkt_sent", 0, pkt_sent);
    @(negedge clk);
    check_eq("line oe", 1, line.oe);
    check_eq("line dp dm", LINE_J, {line.dp, line.dm});
    check_eq("pkt_sent", 1, pkt_sent);
    @(negedge clk);
    check_eq("line oe dp dm", 3'b010, {line.oe, line.dp, line.dm});
    check_eq("pkt_sent", 0, pkt_sent);
    check_eq("busy", 0, busy);
    check_eq("decoded bit count", exp_len, got_len);
    check_eq("decoded bits", exp_seq, got_seq);
    if (s.tag == TAG_DATA_ONES) begin
      assert (stuffed > 0) else begin
        $display("no zero was stuffed into the all-ones payload");
        fail_run();
      end
    end
  endtask

  initial begin
    int       seed;
    payload_t rand_data;
    cycles    = 0;
    rst_L     = 1'b0;
    pkt       = '0;
    pkt_valid = 1'b0;
    seed      = 32'hf463_fdf5;
    rand_data = {$random(seed), $random(seed)};
    stim[0] = make_entry(TAG_HANDSHAKE, PID_ACK, '0, '0, '0);
    stim[1] = make_entry(TAG_HANDSHAKE, PID_NAK, '0, '0, '0);
    stim[2] = make_entry(TAG_TOKEN, PID_OUT, 7'h15, 4'he, '0);
    // all ones in address and endpoint
    stim[3] = make_entry(TAG_TOKEN, PID_IN, 7'h7f, 4'hf, '0);
    stim[4] = make_entry(TAG_DATA_ONES, PID_DATA0, '0, '0, '1);
    stim[5] = make_entry(TAG_DATA, PID_DATA0, '0, '0, '0);
    stim[6] = make_entry(TAG_DATA, PID_DATA0, '0, '0, 64'haaaa_aaaa_aaaa_aaaa);
    stim[7] = make_entry(TAG_DATA, PID_DATA0, '0, '0, rand_data);
    repeat (2) @(posedge clk);
    #2;
    rst_L = 1'b1;
    // idle line before the first strobe
    @(negedge clk);
    check_eq("line oe", 0, line.oe);
    check_eq("busy", 0, busy);
    check_eq("pkt_sent", 0, pkt_sent);
    check_eq("line dp", 1, line.dp);
    check_eq("line dm", 0, line.dm);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      send_and_decode(stim[i]);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+common
+incdir+tests
common/usb_pkt_pkg.sv
common/usb_line_pkg.sv
hw/tx/usb_crc_serial.sv
hw/tx/usb_pkt_encoder.sv
hw/tx/usb_bit_stuffer.sv
hw/usb_line_driver.sv
hw/usb_tx.sv
tests/tb_usb_tx.sv

// ==== run.sh ====
#!/bin/sh
# build and run the usb_tx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_usb_tx -o sim_tb_usb_tx
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb_usb_tx
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi

exit 0
